//--- hdl/hpm_defines.svh
// Sizing macros for the performance monitor. HPM_N_CTR must stay within 1..8,
// as only eight counter and eight event-configuration addresses exist.

`ifndef HPM_DEFINES_SVH
`define HPM_DEFINES_SVH

// Number of event counters
`define HPM_N_CTR 4

// Register word address width
`define HPM_ADDR_W 8

// Register data width, also the event counter width
`define HPM_DATA_W 64

`endif

//--- hdl/hpm_pkg.sv
// Types and register map of the performance monitor.
// Addresses are word addresses on the 64-bit register port.

`include "hpm_defines.svh"

package hpm_pkg;

    // Register port
    typedef logic [`HPM_ADDR_W-1:0] hpm_addr_t;
    typedef logic [`HPM_DATA_W-1:0] hpm_data_t;

    // Counter values, cycle counter loses one bit to its OF flag
    typedef logic [`HPM_DATA_W-1:0] hpm_cnt_t;
    typedef logic [`HPM_DATA_W-2:0] hpm_cyc_t;

    // Transaction IDs
    typedef logic [23:0] hpm_did_t;
    typedef logic [19:0] hpm_pid_t;
    typedef logic [15:0] hpm_gscid_t;

    // Event configuration word minus OF
    typedef logic [`HPM_DATA_W-2:0] hpm_evt_cfg_t;

    // Event IDs, sized to the eventid field
    typedef enum logic [14:0] {
        NONE       = 15'd0,
        UT_REQ     = 15'd1,
        IOTLB_MISS = 15'd2,
        DDTW       = 15'd3,
        PDTW       = 15'd4,
        S1_PTW     = 15'd5,
        S2_PTW     = 15'd6
    } hpm_event_e;

    // Four-phase handshake
    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_LOW
    } hpm_bus_state_e;

    // Register map
    localparam hpm_addr_t ADDR_COUNTINH = 8'h00;
    localparam hpm_addr_t ADDR_IPSR     = 8'h01;
    localparam hpm_addr_t ADDR_CYCLES   = 8'h02;
    localparam hpm_addr_t ADDR_CTR_BASE = 8'h08;
    localparam hpm_addr_t ADDR_EVT_BASE = 8'h10;

endpackage

//--- hdl/hpm_event_filter.sv
// Combinational event selection and ID filtering, zero latency.
// PSCID/GSCID checks only apply to events where those IDs are known.

`timescale 1ns/1ns

`include "hpm_defines.svh"

module hpm_event_filter (
    // Event pulses
    input  logic                                 tr_request_i,
    input  logic                                 iotlb_miss_i,
    input  logic                                 ddt_walk_i,
    input  logic                                 pdt_walk_i,
    input  logic                                 s1_ptw_i,
    input  logic                                 s2_ptw_i,
    // IDs of the current event
    input  hpm_pkg::hpm_did_t                    did_i,
    input  hpm_pkg::hpm_pid_t                    pid_i,
    input  logic                                 pid_v_i,
    input  hpm_pkg::hpm_pid_t                    pscid_i,
    input  hpm_pkg::hpm_gscid_t                  gscid_i,
    // Counter setup
    input  hpm_pkg::hpm_evt_cfg_t [`HPM_N_CTR-1:0] evt_cfg_i,
    input  logic [`HPM_N_CTR-1:0]                ctr_inh_i,
    output logic [`HPM_N_CTR-1:0]                inc_req_o
);

    // Exact or masked ID compare
    // with dmask, bits at and below the lowest zero of cfg_id are don't care
    function automatic logic id_match(
        input hpm_pkg::hpm_did_t id,
        input hpm_pkg::hpm_did_t cfg_id,
        input logic              dmask
    );
        hpm_pkg::hpm_did_t care;
        // cfg_id ^ (cfg_id + 1) marks trailing ones plus the lowest zero
        care = dmask ? ~(cfg_id ^ (cfg_id + 24'd1)) : '1;
        return ((id ^ cfg_id) & care) == '0;
    endfunction

    always_comb begin
        hpm_pkg::hpm_event_e evt_id;
        logic                evt_hit;
        logic                pscid_known;
        logic                gscid_known;
        logic                did_ok;
        logic                pid_ok;
        logic                pscid_ok;
        logic                gscid_ok;
        logic                id_ok;

        for (int i = 0; i < `HPM_N_CTR; i++) begin
            evt_id = hpm_pkg::hpm_event_e'(evt_cfg_i[i][14:0]);

            // Pick the configured event pulse
            case (evt_id)
                hpm_pkg::UT_REQ:     evt_hit = tr_request_i;
                hpm_pkg::IOTLB_MISS: evt_hit = iotlb_miss_i;
                hpm_pkg::DDTW:       evt_hit = ddt_walk_i;
                hpm_pkg::PDTW:       evt_hit = pdt_walk_i;
                hpm_pkg::S1_PTW:     evt_hit = s1_ptw_i;
                hpm_pkg::S2_PTW:     evt_hit = s2_ptw_i;
                default:             evt_hit = 1'b0;
            endcase

            // PSCID exists only once the context is resolved
            pscid_known = (evt_id == hpm_pkg::IOTLB_MISS) ||
                          (evt_id == hpm_pkg::S1_PTW) ||
                          (evt_id == hpm_pkg::S2_PTW);
            // GSCID is also known during a PDT walk
            gscid_known = pscid_known || (evt_id == hpm_pkg::PDTW);

            // did_gscid is bits 59:36, pid_pscid is bits 35:16, dmask is bit 15
            did_ok = id_match(did_i, evt_cfg_i[i][59:36], evt_cfg_i[i][15]);
            pid_ok = pid_v_i && (pid_i == evt_cfg_i[i][35:16]);

            // Unknown IDs never block counting
            pscid_ok = !pscid_known || (pscid_i == evt_cfg_i[i][35:16]);
            gscid_ok = !gscid_known ||
                       id_match({8'h00, gscid_i}, {8'h00, evt_cfg_i[i][51:36]},
                                evt_cfg_i[i][15]);

            // Mode is {idt, dv_gscv, pv_pscv}
            case (evt_cfg_i[i][62:60])
                3'b001:  id_ok = pid_ok;
                3'b010:  id_ok = did_ok;
                3'b011:  id_ok = did_ok && pid_ok;
                3'b101:  id_ok = pscid_ok;
                3'b110:  id_ok = gscid_ok;
                3'b111:  id_ok = gscid_ok && pscid_ok;
                // No filter
                default: id_ok = 1'b1;
            endcase

            inc_req_o[i] = evt_hit && id_ok && !ctr_inh_i[i];
        end
    end

endmodule

//--- hdl/hpm_counters.sv
// Counter storage. A software write to a counter beats counting in the same cycle.
// pmip is raised only by a counting overflow while that counter's OF is clear.

`timescale 1ns/1ns

`include "hpm_defines.svh"

module hpm_counters (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // Counting controls
    input  logic [`HPM_N_CTR-1:0]               inc_req_i,
    input  logic                                cy_inh_i,
    // Software write path
    input  logic                                sw_wr_i,
    input  hpm_pkg::hpm_addr_t                  sw_addr_i,
    input  hpm_pkg::hpm_data_t                  sw_wdata_i,
    // Readback
    output hpm_pkg::hpm_data_t                  cyc_rd_o,
    output hpm_pkg::hpm_cnt_t [`HPM_N_CTR-1:0]  ctr_rd_o,
    output logic [`HPM_N_CTR-1:0]               evt_of_o,
    output logic                                pmip_o
);

    hpm_pkg::hpm_cyc_t                  cyc_q;
    logic                               cyc_of_q;
    hpm_pkg::hpm_cnt_t [`HPM_N_CTR-1:0] ctr_q;
    logic [`HPM_N_CTR-1:0]              evt_of_q;
    logic                               pmip_q;

    // Write decode
    logic                               ipsr_wr;
    logic                               cyc_wr;
    logic [`HPM_N_CTR-1:0]              ctr_wr;
    logic [`HPM_N_CTR-1:0]              evt_wr;

    // Overflow this cycle
    logic                               cyc_ovf;
    logic [`HPM_N_CTR-1:0]              ctr_ovf;
    logic                               pmip_set;

    assign ipsr_wr = sw_wr_i && (sw_addr_i == hpm_pkg::ADDR_IPSR);
    assign cyc_wr  = sw_wr_i && (sw_addr_i == hpm_pkg::ADDR_CYCLES);

    always_comb begin
        for (int i = 0; i < `HPM_N_CTR; i++) begin
            ctr_wr[i] = sw_wr_i &&
                (sw_addr_i == hpm_pkg::ADDR_CTR_BASE + hpm_pkg::hpm_addr_t'(i));
            evt_wr[i] = sw_wr_i &&
                (sw_addr_i == hpm_pkg::ADDR_EVT_BASE + hpm_pkg::hpm_addr_t'(i));
        end
    end

    // All ones and counting means wrap
    assign cyc_ovf = !cy_inh_i && (&cyc_q) && !cyc_wr;

    always_comb begin
        for (int i = 0; i < `HPM_N_CTR; i++) begin
            ctr_ovf[i] = inc_req_i[i] && (&ctr_q[i]) && !ctr_wr[i];
        end
    end

    // Old OF gates the interrupt, so software-set OF stays silent
    assign pmip_set = (cyc_ovf && !cyc_of_q) || (|(ctr_ovf & ~evt_of_q));

    // Cycle counter and its OF
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cyc_q    <= '0;
            cyc_of_q <= 1'b0;
        end else if (cyc_wr) begin
            cyc_q    <= sw_wdata_i[`HPM_DATA_W-2:0];
            cyc_of_q <= sw_wdata_i[`HPM_DATA_W-1];
        end else if (!cy_inh_i) begin
            cyc_q <= cyc_q + 1'b1;
            if (cyc_ovf) begin
                cyc_of_q <= 1'b1;
            end
        end
    end

    // Event counters and OF bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctr_q    <= '0;
            evt_of_q <= '0;
        end else begin
            for (int i = 0; i < `HPM_N_CTR; i++) begin
                if (ctr_wr[i]) begin
                    ctr_q[i] <= sw_wdata_i;
                end else if (inc_req_i[i]) begin
                    ctr_q[i] <= ctr_q[i] + 1'b1;
                end
                // OF lives in the event config word
                if (evt_wr[i]) begin
                    evt_of_q[i] <= sw_wdata_i[`HPM_DATA_W-1];
                end else if (ctr_ovf[i]) begin
                    evt_of_q[i] <= 1'b1;
                end
            end
        end
    end

    // Sticky pending bit, W1C, new overflow wins over clear
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pmip_q <= 1'b0;
        end else if (pmip_set) begin
            pmip_q <= 1'b1;
        end else if (ipsr_wr && sw_wdata_i[0]) begin
            pmip_q <= 1'b0;
        end
    end

    assign cyc_rd_o = {cyc_of_q, cyc_q};
    assign ctr_rd_o = ctr_q;
    assign evt_of_o = evt_of_q;
    assign pmip_o   = pmip_q;

endmodule

//--- hdl/hpm_regs.sv
// Four-phase req/ack register port. Unmapped reads return zero, writes are dropped.
// Only N+1 inhibit bits exist, so writing all ones reveals the counter count.

`timescale 1ns/1ns

`include "hpm_defines.svh"

module hpm_regs (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    // Register port
    input  logic                                   req_i,
    input  logic                                   we_i,
    input  hpm_pkg::hpm_addr_t                     addr_i,
    input  hpm_pkg::hpm_data_t                     wdata_i,
    output logic                                   ack_o,
    output hpm_pkg::hpm_data_t                     rdata_o,
    // Configuration out
    output logic                                   cy_inh_o,
    output logic [`HPM_N_CTR-1:0]                  ctr_inh_o,
    output hpm_pkg::hpm_evt_cfg_t [`HPM_N_CTR-1:0] evt_cfg_o,
    // Write forward to counter storage
    output logic                                   sw_wr_o,
    output hpm_pkg::hpm_addr_t                     sw_addr_o,
    output hpm_pkg::hpm_data_t                     sw_wdata_o,
    // Counter readback
    input  hpm_pkg::hpm_data_t                     cyc_rd_i,
    input  hpm_pkg::hpm_cnt_t [`HPM_N_CTR-1:0]     ctr_rd_i,
    input  logic [`HPM_N_CTR-1:0]                  evt_of_i,
    input  logic                                   pmip_i
);

    hpm_pkg::hpm_bus_state_e               state_q;
    logic                                  accept;
    logic                                  wr_en;

    logic                                  cy_inh_q;
    logic [`HPM_N_CTR-1:0]                 ctr_inh_q;
    hpm_pkg::hpm_evt_cfg_t [`HPM_N_CTR-1:0] evt_cfg_q;

    hpm_pkg::hpm_data_t                    rd_mux;

    // Request sampled in IDLE
    assign accept = (state_q == hpm_pkg::IDLE) && req_i;
    assign wr_en  = accept && we_i;

    // Handshake FSM
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= hpm_pkg::IDLE;
        end else begin
            case (state_q)
                hpm_pkg::IDLE: begin
                    if (req_i) begin
                        state_q <= hpm_pkg::ACK;
                    end
                end
                // Hold ack until master drops req
                hpm_pkg::ACK: begin
                    if (!req_i) begin
                        state_q <= hpm_pkg::WAIT_LOW;
                    end
                end
                // One idle turnaround with ack low
                hpm_pkg::WAIT_LOW: state_q <= hpm_pkg::IDLE;
                default:           state_q <= hpm_pkg::IDLE;
            endcase
        end
    end

    assign ack_o = (state_q == hpm_pkg::ACK);

    // Inhibit and event configuration storage
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cy_inh_q  <= 1'b1;
            ctr_inh_q <= '1;
            evt_cfg_q <= '0;
        end else if (wr_en) begin
            if (addr_i == hpm_pkg::ADDR_COUNTINH) begin
                cy_inh_q  <= wdata_i[0];
                ctr_inh_q <= wdata_i[`HPM_N_CTR:1];
            end
            for (int i = 0; i < `HPM_N_CTR; i++) begin
                if (addr_i == hpm_pkg::ADDR_EVT_BASE + hpm_pkg::hpm_addr_t'(i)) begin
                    evt_cfg_q[i] <= wdata_i[`HPM_DATA_W-2:0];
                end
            end
        end
    end

    // Read mux, zero outside the map
    always_comb begin
        rd_mux = '0;
        case (addr_i)
            hpm_pkg::ADDR_COUNTINH: rd_mux[`HPM_N_CTR:0] = {ctr_inh_q, cy_inh_q};
            hpm_pkg::ADDR_IPSR:     rd_mux[0] = pmip_i;
            hpm_pkg::ADDR_CYCLES:   rd_mux = cyc_rd_i;
            default:                rd_mux = '0;
        endcase
        for (int i = 0; i < `HPM_N_CTR; i++) begin
            if (addr_i == hpm_pkg::ADDR_CTR_BASE + hpm_pkg::hpm_addr_t'(i)) begin
                rd_mux = ctr_rd_i[i];
            end
            if (addr_i == hpm_pkg::ADDR_EVT_BASE + hpm_pkg::hpm_addr_t'(i)) begin
                rd_mux = {evt_of_i[i], evt_cfg_q[i]};
            end
        end
    end

    // Captured on the accepting edge, held through ack
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rdata_o <= rd_mux;
        end
    end

    // Counter storage decodes the address itself
    assign sw_wr_o    = wr_en;
    assign sw_addr_o  = addr_i;
    assign sw_wdata_o = wdata_i;

    assign cy_inh_o   = cy_inh_q;
    assign ctr_inh_o  = ctr_inh_q;
    assign evt_cfg_o  = evt_cfg_q;

endmodule

//--- hdl/iommu_hpm_top.sv
// IOMMU performance monitor top. Event inputs are one-cycle pulses with IDs valid
// in the same cycle. hpm_ip_o is the sticky ipsr.pmip bit.

`timescale 1ns/1ns

`include "hpm_defines.svh"

module iommu_hpm_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // Register port
    input  logic                 req_i,
    input  logic                 we_i,
    input  hpm_pkg::hpm_addr_t   addr_i,
    input  hpm_pkg::hpm_data_t   wdata_i,
    output logic                 ack_o,
    output hpm_pkg::hpm_data_t   rdata_o,
    // Translation events
    input  logic                 tr_request_i,
    input  logic                 iotlb_miss_i,
    input  logic                 ddt_walk_i,
    input  logic                 pdt_walk_i,
    input  logic                 s1_ptw_i,
    input  logic                 s2_ptw_i,
    // Event IDs
    input  hpm_pkg::hpm_did_t    did_i,
    input  hpm_pkg::hpm_pid_t    pid_i,
    input  logic                 pid_v_i,
    input  hpm_pkg::hpm_pid_t    pscid_i,
    input  hpm_pkg::hpm_gscid_t  gscid_i,
    // Pending interrupt
    output logic                 hpm_ip_o
);

    logic                                   cy_inh;
    logic [`HPM_N_CTR-1:0]                  ctr_inh;
    hpm_pkg::hpm_evt_cfg_t [`HPM_N_CTR-1:0] evt_cfg;
    logic                                   sw_wr;
    hpm_pkg::hpm_addr_t                     sw_addr;
    hpm_pkg::hpm_data_t                     sw_wdata;
    hpm_pkg::hpm_data_t                     cyc_rd;
    hpm_pkg::hpm_cnt_t [`HPM_N_CTR-1:0]     ctr_rd;
    logic [`HPM_N_CTR-1:0]                  evt_of;
    logic [`HPM_N_CTR-1:0]                  inc_req;

    hpm_regs u_regs (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .ack_o      (ack_o),
        .rdata_o    (rdata_o),
        .cy_inh_o   (cy_inh),
        .ctr_inh_o  (ctr_inh),
        .evt_cfg_o  (evt_cfg),
        .sw_wr_o    (sw_wr),
        .sw_addr_o  (sw_addr),
        .sw_wdata_o (sw_wdata),
        .cyc_rd_i   (cyc_rd),
        .ctr_rd_i   (ctr_rd),
        .evt_of_i   (evt_of),
        .pmip_i     (hpm_ip_o)
    );

    hpm_event_filter u_filter (
        .tr_request_i (tr_request_i),
        .iotlb_miss_i (iotlb_miss_i),
        .ddt_walk_i   (ddt_walk_i),
        .pdt_walk_i   (pdt_walk_i),
        .s1_ptw_i     (s1_ptw_i),
        .s2_ptw_i     (s2_ptw_i),
        .did_i        (did_i),
        .pid_i        (pid_i),
        .pid_v_i      (pid_v_i),
        .pscid_i      (pscid_i),
        .gscid_i      (gscid_i),
        .evt_cfg_i    (evt_cfg),
        .ctr_inh_i    (ctr_inh),
        .inc_req_o    (inc_req)
    );

    hpm_counters u_counters (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .inc_req_i  (inc_req),
        .cy_inh_i   (cy_inh),
        .sw_wr_i    (sw_wr),
        .sw_addr_i  (sw_addr),
        .sw_wdata_i (sw_wdata),
        .cyc_rd_o   (cyc_rd),
        .ctr_rd_o   (ctr_rd),
        .evt_of_o   (evt_of),
        .pmip_o     (hpm_ip_o)
    );

endmodule

//--- verification/hpm_tb_tasks.svh
// Bus, event and check tasks, included inside the testbench module.
// Tests below need HPM_N_CTR of at least 4.

`ifndef HPM_TB_TASKS_SVH
`define HPM_TB_TASKS_SVH

// Register addresses of counter i and its event config
function automatic logic [7:0] ctr_addr(input int i);
    return hpm_pkg::ADDR_CTR_BASE + 8'(i);
endfunction

function automatic logic [7:0] evt_addr(input int i);
    return hpm_pkg::ADDR_EVT_BASE + 8'(i);
endfunction

// Event config word built from its fields, OF left clear
function automatic logic [63:0] evt_word(
    input hpm_pkg::hpm_event_e evt,
    input logic [2:0]          mode,
    input logic                dmask,
    input logic [19:0]         pid,
    input logic [23:0]         did
);
    logic [63:0] w;
    w         = 64'd0;
    w[14:0]   = evt;
    w[15]     = dmask;
    w[35:16]  = pid;
    w[59:36]  = did;
    w[62:60]  = mode;
    return w;
endfunction

// Polls ack_o just after each edge
task automatic wait_ack(input logic level);
    do begin
        @(posedge clk_i);
        #10;
    end while (ack_o !== level);
endtask

// One full four-phase transaction
task automatic bus_xfer(
    input  logic        we,
    input  logic [7:0]  addr,
    input  logic [63:0] wdata,
    output logic [63:0] rdata
);
    @(posedge clk_i);
    #10;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    wait_ack(1'b1);
    rdata = rdata_o;
    req_i = 1'b0;
    we_i  = 1'b0;
    wait_ack(1'b0);
endtask

task automatic bus_write(input logic [7:0] addr, input logic [63:0] data);
    logic [63:0] discard;
    bus_xfer(1'b1, addr, data, discard);
endtask

task automatic bus_read(input logic [7:0] addr, output logic [63:0] data);
    bus_xfer(1'b0, addr, 64'd0, data);
endtask

// Single-cycle event pulse with its IDs
task automatic pulse_event(
    input hpm_pkg::hpm_event_e evt,
    input logic [23:0]         did,
    input logic [19:0]         pid,
    input logic                pid_v,
    input logic [19:0]         pscid,
    input logic [15:0]         gscid
);
    @(posedge clk_i);
    #10;
    did_i        = did;
    pid_i        = pid;
    pid_v_i      = pid_v;
    pscid_i      = pscid;
    gscid_i      = gscid;
    tr_request_i = (evt == hpm_pkg::UT_REQ);
    iotlb_miss_i = (evt == hpm_pkg::IOTLB_MISS);
    ddt_walk_i   = (evt == hpm_pkg::DDTW);
    pdt_walk_i   = (evt == hpm_pkg::PDTW);
    s1_ptw_i     = (evt == hpm_pkg::S1_PTW);
    s2_ptw_i     = (evt == hpm_pkg::S2_PTW);
    @(posedge clk_i);
    #10;
    tr_request_i = 1'b0;
    iotlb_miss_i = 1'b0;
    ddt_walk_i   = 1'b0;
    pdt_walk_i   = 1'b0;
    s1_ptw_i     = 1'b0;
    s2_ptw_i     = 1'b0;
endtask

task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
        $display("error %s, %s: expected %h, actual %h", cur_test, what, exp, act);
        test_errors++;
    end
endtask

task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
endtask

// One line per finished test
task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
        tests_ok++;
        $display("%s: ok", cur_test);
    end else begin
        $display("%s: %0d mismatches", cur_test, test_errors);
    end
endtask

`endif

//--- verification/tb_iommu_hpm.sv
// Directed testbench for the performance monitor with a fixed random seed.
// Needs HPM_N_CTR of at least 4 and stops the run after 20000 cycles.

`timescale 1ns/1ns

`include "hpm_defines.svh"

module tb_iommu_hpm;

    localparam int          TIMEOUT_CYCLES = 20000;
    localparam logic [63:0] INH_ALL = (64'd1 << (`HPM_N_CTR + 1)) - 64'd1;

    logic        clk_i;
    logic        rst_n_i;
    logic        req_i;
    logic        we_i;
    logic [7:0]  addr_i;
    logic [63:0] wdata_i;
    logic        ack_o;
    logic [63:0] rdata_o;
    logic        tr_request_i;
    logic        iotlb_miss_i;
    logic        ddt_walk_i;
    logic        pdt_walk_i;
    logic        s1_ptw_i;
    logic        s2_ptw_i;
    logic [23:0] did_i;
    logic [19:0] pid_i;
    logic        pid_v_i;
    logic [19:0] pscid_i;
    logic [15:0] gscid_i;
    logic        hpm_ip_o;

    // Bookkeeping
    string cur_test;
    int    test_errors;
    int    total_errors;
    int    tests_run;
    int    tests_ok;
    int    cycle_cnt;

    `include "hpm_tb_tasks.svh"

    iommu_hpm_top u_iommu_hpm_top (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .we_i         (we_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .ack_o        (ack_o),
        .rdata_o      (rdata_o),
        .tr_request_i (tr_request_i),
        .iotlb_miss_i (iotlb_miss_i),
        .ddt_walk_i   (ddt_walk_i),
        .pdt_walk_i   (pdt_walk_i),
        .s1_ptw_i     (s1_ptw_i),
        .s2_ptw_i     (s2_ptw_i),
        .did_i        (did_i),
        .pid_i        (pid_i),
        .pid_v_i      (pid_v_i),
        .pscid_i      (pscid_i),
        .gscid_i      (gscid_i),
        .hpm_ip_o     (hpm_ip_o)
    );

    // 100 ns clock
    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Watchdog
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the test sequence did not finish within %0d cycles", cycle_cnt);
            $display("tests failed");
            $finish;
        end
    end

    task automatic test_reset_discovery;
        logic [63:0] rd;
        begin_test("reset_discovery");
        bus_read(hpm_pkg::ADDR_COUNTINH, rd);
        check_value("countinh after reset", INH_ALL, rd);
        check_value("hpm_ip_o after reset", 64'd0, 64'(hpm_ip_o));
        // Only implemented inhibit bits stick
        bus_write(hpm_pkg::ADDR_COUNTINH, '1);
        bus_read(hpm_pkg::ADDR_COUNTINH, rd);
        check_value("countinh all ones", INH_ALL, rd);
        if (`HPM_N_CTR < 8) begin
            bus_write(ctr_addr(`HPM_N_CTR), '1);
            bus_read(ctr_addr(`HPM_N_CTR), rd);
            check_value("counter above N", 64'd0, rd);
        end
        end_test();
    endtask

    task automatic test_cycle_counter;
        logic [63:0] a;
        logic [63:0] b;
        begin_test("cycle_counter");
        // Inhibited since reset, so still at its reset value
        bus_read(hpm_pkg::ADDR_CYCLES, a);
        bus_read(hpm_pkg::ADDR_CYCLES, b);
        check_value("inhibited cycles first", 64'd0, a);
        check_value("inhibited cycles second", 64'd0, b);
        // Release cy only
        bus_write(hpm_pkg::ADDR_COUNTINH, INH_ALL & ~64'd1);
        bus_read(hpm_pkg::ADDR_CYCLES, a);
        repeat (5) @(posedge clk_i);
        bus_read(hpm_pkg::ADDR_CYCLES, b);
        check_value("cycles advance", 64'd1, 64'(b[62:0] > a[62:0]));
        end_test();
    endtask

    task automatic test_unfiltered_count;
        logic [63:0]         rd;
        int unsigned         n;
        hpm_pkg::hpm_event_e evt;
        hpm_pkg::hpm_event_e other;
        begin_test("unfiltered_count");
        // Counter 2 inhibited, the rest counting
        bus_write(hpm_pkg::ADDR_COUNTINH, 64'h08);
        for (int e = 1; e <= 6; e++) begin
            evt   = hpm_pkg::hpm_event_e'(15'(e));
            other = hpm_pkg::hpm_event_e'(15'(e % 6 + 1));
            bus_write(evt_addr(0), evt_word(evt, 3'b000, 1'b0, '0, '0));
            bus_write(evt_addr(1), evt_word(other, 3'b000, 1'b0, '0, '0));
            bus_write(evt_addr(2), evt_word(evt, 3'b000, 1'b0, '0, '0));
            for (int i = 0; i < 3; i++) begin
                bus_write(ctr_addr(i), 64'd0);
            end
            n = $urandom_range(8, 1);
            repeat (n) pulse_event(evt, '0, '0, 1'b0, '0, '0);
            bus_read(ctr_addr(0), rd);
            check_value("matching counter", 64'(n), rd);
            bus_read(ctr_addr(1), rd);
            check_value("other event counter", 64'd0, rd);
            bus_read(ctr_addr(2), rd);
            check_value("inhibited counter", 64'd0, rd);
        end
        end_test();
    endtask

    task automatic test_id_filter;
        logic [63:0] rd;
        logic [23:0] did;
        logic [19:0] pid;
        logic [15:0] gscid;
        did   = 24'($urandom);
        pid   = 20'($urandom);
        gscid = 16'($urandom);
        begin_test("id_filter");
        bus_write(hpm_pkg::ADDR_COUNTINH, 64'd0);
        // Exact did, masked did on bits 23:8, pid, GSCID on DDTW
        bus_write(evt_addr(0), evt_word(hpm_pkg::UT_REQ, 3'b010, 1'b0, '0, did));
        bus_write(evt_addr(1), evt_word(hpm_pkg::UT_REQ, 3'b010, 1'b1, '0,
                                        {did[23:8], 8'h7f}));
        bus_write(evt_addr(2), evt_word(hpm_pkg::UT_REQ, 3'b001, 1'b0, pid, '0));
        bus_write(evt_addr(3), evt_word(hpm_pkg::DDTW, 3'b110, 1'b0, '0, {8'h00, gscid}));
        for (int i = 0; i < 4; i++) begin
            bus_write(ctr_addr(i), 64'd0);
        end
        pulse_event(hpm_pkg::UT_REQ, did, pid, 1'b1, '0, '0);
        pulse_event(hpm_pkg::UT_REQ, {did[23:8], ~did[7:0]}, pid, 1'b0, '0, '0);
        pulse_event(hpm_pkg::UT_REQ, did ^ 24'h01_0000, pid ^ 20'h1, 1'b1, '0, '0);
        // GSCID unknown on a DDT walk
        pulse_event(hpm_pkg::DDTW, '0, '0, 1'b0, '0, gscid ^ 16'h1);
        pulse_event(hpm_pkg::DDTW, '0, '0, 1'b0, '0, gscid);
        bus_read(ctr_addr(0), rd);
        check_value("exact did", 64'd1, rd);
        bus_read(ctr_addr(1), rd);
        check_value("masked did", 64'd2, rd);
        bus_read(ctr_addr(2), rd);
        check_value("pid with pid_v", 64'd1, rd);
        bus_read(ctr_addr(3), rd);
        check_value("gscid on ddtw", 64'd2, rd);
        // GSCID known on an IOTLB miss
        bus_write(evt_addr(3), evt_word(hpm_pkg::IOTLB_MISS, 3'b110, 1'b0, '0,
                                        {8'h00, gscid}));
        bus_write(ctr_addr(3), 64'd0);
        pulse_event(hpm_pkg::IOTLB_MISS, '0, '0, 1'b0, '0, gscid ^ 16'h1);
        pulse_event(hpm_pkg::IOTLB_MISS, '0, '0, 1'b0, '0, gscid);
        bus_read(ctr_addr(3), rd);
        check_value("gscid on iotlb miss", 64'd1, rd);
        end_test();
    endtask

    task automatic test_overflow_irq;
        logic [63:0] rd;
        begin_test("overflow_irq");
        bus_write(evt_addr(0), evt_word(hpm_pkg::S1_PTW, 3'b000, 1'b0, '0, '0));
        bus_write(ctr_addr(0), '1);
        pulse_event(hpm_pkg::S1_PTW, '0, '0, 1'b0, '0, '0);
        bus_read(ctr_addr(0), rd);
        check_value("wrapped counter", 64'd0, rd);
        bus_read(evt_addr(0), rd);
        check_value("OF after overflow", 64'd1, 64'(rd[63]));
        check_value("hpm_ip_o after overflow", 64'd1, 64'(hpm_ip_o));
        // W1C
        bus_write(hpm_pkg::ADDR_IPSR, 64'd1);
        check_value("hpm_ip_o after clear", 64'd0, 64'(hpm_ip_o));
        // Second wrap with OF already set raises nothing
        bus_write(ctr_addr(0), '1);
        pulse_event(hpm_pkg::S1_PTW, '0, '0, 1'b0, '0, '0);
        bus_read(ctr_addr(0), rd);
        check_value("second wrap", 64'd0, rd);
        check_value("hpm_ip_o second overflow", 64'd0, 64'(hpm_ip_o));
        // OF written by software
        bus_write(evt_addr(1), {1'b1, 63'd0} | evt_word(hpm_pkg::UT_REQ, 3'b000, 1'b0, '0, '0));
        bus_read(evt_addr(1), rd);
        check_value("software OF", 64'd1, 64'(rd[63]));
        check_value("hpm_ip_o software OF", 64'd0, 64'(hpm_ip_o));
        bus_read(hpm_pkg::ADDR_IPSR, rd);
        check_value("ipsr software OF", 64'd0, rd);
        end_test();
    endtask

    task automatic test_handshake;
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] rd;
        x = {1'b0, $urandom, 31'($urandom)};
        y = {1'b0, $urandom, 31'($urandom)};
        begin_test("handshake");
        bus_write(evt_addr(2), x);
        bus_write(evt_addr(3), y);
        // Slow master holds req
        @(posedge clk_i);
        #10;
        req_i  = 1'b1;
        we_i   = 1'b0;
        addr_i = evt_addr(2);
        wait_ack(1'b1);
        repeat (4) begin
            @(posedge clk_i);
            #10;
            check_value("ack held", 64'd1, 64'(ack_o));
        end
        check_value("held read data", x, rdata_o);
        req_i = 1'b0;
        @(posedge clk_i);
        #10;
        check_value("ack released", 64'd0, 64'(ack_o));
        // Back to back
        bus_read(evt_addr(3), rd);
        check_value("back to back first", y, rd);
        bus_read(evt_addr(2), rd);
        check_value("back to back second", x, rd);
        end_test();
    endtask

    initial begin
        void'($urandom(32'h43b0_3486));
        cycle_cnt    = 0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_ok     = 0;
        rst_n_i      = 1'b0;
        req_i        = 1'b0;
        we_i         = 1'b0;
        addr_i       = '0;
        wdata_i      = '0;
        tr_request_i = 1'b0;
        iotlb_miss_i = 1'b0;
        ddt_walk_i   = 1'b0;
        pdt_walk_i   = 1'b0;
        s1_ptw_i     = 1'b0;
        s2_ptw_i     = 1'b0;
        did_i        = '0;
        pid_i        = '0;
        pid_v_i      = 1'b0;
        pscid_i      = '0;
        gscid_i      = '0;
        repeat (8) @(posedge clk_i);
        #10;
        rst_n_i = 1'b1;

        test_reset_discovery();
        test_cycle_counter();
        test_unfiltered_count();
        test_id_filter();
        test_overflow_irq();
        test_handshake();

        $display("%0d of %0d tests ok, %0d mismatches", tests_ok, tests_run, total_errors);
        if (total_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+hdl
+incdir+verification
hdl/hpm_pkg.sv
hdl/hpm_event_filter.sv
hdl/hpm_counters.sv
hdl/hpm_regs.sv
hdl/iommu_hpm_top.sv
verification/tb_iommu_hpm.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_iommu_hpm -o sim_tb_iommu_hpm

sim_out=$(./obj_dir/sim_tb_iommu_hpm)
echo "$sim_out"

if echo "$sim_out" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi
